// File: armIsaPkg.sv
`default_nettype none

package armIsaPkg;

  // ====================
  // Instruction word
  // ====================
  localparam int instrW = 32;
  typedef logic [instrW-1:0] instrT;

  // Field boundaries
  localparam int condHi   = 31;
  localparam int condLo   = 28;
  localparam int classHi  = 27;
  localparam int classLo  = 26;
  localparam int opcodeHi = 24; // DP opcode, goes straight to the ALU
  localparam int opcodeLo = 21;
  localparam int rdHi     = 15;
  localparam int rdLo     = 12;

  // Single-bit fields
  localparam int bitImm  = 25; // DP: immediate operand; LDR/STR: set means register offset
  localparam int bitUp   = 23; // Add or subtract the offset
  localparam int bitByte = 22;
  localparam int bitLoad = 20;
  localparam int bitS    = 20; // Same slot as L, the class tells them apart

  // Bits 27:26
  typedef enum logic [1:0] {
    dataProc  = 2'b00,
    loadStore = 2'b01,
    branch    = 2'b10, // Only 101 is B, 100 is LDM/STM
    other     = 2'b11  // Coprocessor and SWI space
  } opClassT;

  typedef enum logic [3:0] {
    condEQ = 4'h0, condNE = 4'h1, condCS = 4'h2, condCC = 4'h3,
    condMI = 4'h4, condPL = 4'h5, condVS = 4'h6, condVC = 4'h7,
    condHI = 4'h8, condLS = 4'h9, condGE = 4'hA, condLT = 4'hB,
    condGT = 4'hC, condLE = 4'hD, condAL = 4'hE, condNV = 4'hF
  } condT;

endpackage

`default_nettype wire

// File: ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  // ====================
  // ALU control
  // ====================
  typedef logic [3:0] aluCtlT; // Same coding as the DP opcode field

  localparam aluCtlT aluAdd = 4'b0100; // Loads, stores with U set, branches
  localparam aluCtlT aluSub = 4'b0010; // Loads and stores with U clear
  localparam aluCtlT aluMov = 4'b1101;
  localparam aluCtlT aluRsb = 4'b0011;
  localparam aluCtlT aluCmp = 4'b1010;

  // ====================
  // Flags
  // ====================
  typedef logic [3:0] flagsT; // NZCV

  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // Flag write enables, one per pair
  typedef logic [1:0] flagWriteT;

  localparam int fwNZ = 1;
  localparam int fwCV = 0;

  // Memory and operand select
  typedef logic [3:0] byteMaskT; // Lane i is byte i, little endian
  typedef logic [1:0] srcSelT;   // regSrc and immSrc

  localparam byteMaskT laneAll = 4'b1111;
  localparam logic [3:0] pcReg = 4'd15; // R15

endpackage

`default_nettype wire

// File: condCheck.sv
`timescale 1ns/1ps
`default_nettype none

module condCheck (
  input  wire armIsaPkg::condT     condE,
  input  wire ctrlPkg::flagsT      flagsE,     // Forwarded NZCV
  input  wire ctrlPkg::flagsT      aluFlagsE,
  input  wire ctrlPkg::flagWriteT  flagWriteE,
  output logic                     condExE,
  output ctrlPkg::flagsT           flagsNextE,
  output logic                     setNextFlagsE
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flagsE[ctrlPkg::flagN];
  assign z = flagsE[ctrlPkg::flagZ];
  assign c = flagsE[ctrlPkg::flagC];
  assign v = flagsE[ctrlPkg::flagV];

  // ====================
  // Condition field
  // ====================
  always_comb begin
    case (condE)
      armIsaPkg::condEQ: condExE = z;
      armIsaPkg::condNE: condExE = ~z;
      armIsaPkg::condCS: condExE = c;
      armIsaPkg::condCC: condExE = ~c;
      armIsaPkg::condMI: condExE = n;
      armIsaPkg::condPL: condExE = ~n;
      armIsaPkg::condVS: condExE = v;
      armIsaPkg::condVC: condExE = ~v;
      armIsaPkg::condHI: condExE = c & ~z;        // Unsigned higher
      armIsaPkg::condLS: condExE = ~c | z;
      armIsaPkg::condGE: condExE = (n == v);      // Signed compare
      armIsaPkg::condLT: condExE = (n != v);
      armIsaPkg::condGT: condExE = ~z & (n == v);
      armIsaPkg::condLE: condExE = z | (n != v);
      armIsaPkg::condAL: condExE = 1'b1;
      default:           condExE = 1'b0;          // NV never executes
    endcase
  end

  // Next flags, pairwise from the ALU
  always_comb begin
    flagsNextE = flagsE;
    if (flagWriteE[ctrlPkg::fwNZ]) begin
      flagsNextE[ctrlPkg::flagN] = aluFlagsE[ctrlPkg::flagN];
      flagsNextE[ctrlPkg::flagZ] = aluFlagsE[ctrlPkg::flagZ];
    end
    if (flagWriteE[ctrlPkg::fwCV]) begin
      flagsNextE[ctrlPkg::flagC] = aluFlagsE[ctrlPkg::flagC];
      flagsNextE[ctrlPkg::flagV] = aluFlagsE[ctrlPkg::flagV];
    end
  end

  assign setNextFlagsE = (|flagWriteE) & condExE; // Skipped instructions leave flags alone

endmodule

`default_nettype wire

// File: mainDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
  input  wire logic              clk,
  input  wire logic              arstN,
  input  wire armIsaPkg::instrT  instrD,
  input  wire logic              stallD,
  input  wire logic              flushD,
  output ctrlPkg::srcSelT        regSrcD,
  output ctrlPkg::srcSelT        immSrcD,
  output logic                   aluSrcD,
  output logic                   memtoRegD,
  output logic                   regWriteD,
  output logic                   memWriteD,
  output logic                   branchD,
  output logic                   pcSrcD,
  output logic                   byteD,
  output ctrlPkg::aluCtlT        aluControlD,
  output ctrlPkg::flagWriteT     flagWriteD
);

  armIsaPkg::opClassT opClass;
  logic [8:0]         ctlWord;     // {regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch}
  logic               liveD;       // Low right after a Decode flush
  logic               memtoRegRaw;
  logic               regWriteRaw;
  logic               memWriteRaw;
  logic               isLoadStore;
  logic               isDataProc;

  assign opClass     = armIsaPkg::opClassT'(instrD[armIsaPkg::classHi:armIsaPkg::classLo]);
  assign isLoadStore = (opClass == armIsaPkg::loadStore);
  assign isDataProc  = (opClass == armIsaPkg::dataProc);

  // Flush tracking, held through a stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      liveD <= 1'b0;
    end else if (flushD) begin
      liveD <= 1'b0; // Flush wins over stall
    end else if (!stallD) begin
      liveD <= 1'b1;
    end
  end

  // ====================
  // Main control word
  // ====================
  always_comb begin
    ctlWord = 9'b0; // Dropped classes decode to nothing
    case (opClass)
      armIsaPkg::dataProc: begin
        if (instrD[armIsaPkg::bitImm]) ctlWord = 9'b00_00_1_0_1_0_0; // DP immediate
        else                           ctlWord = 9'b00_00_0_0_1_0_0; // DP register, word multiply too
      end
      armIsaPkg::loadStore: begin
        case ({instrD[armIsaPkg::bitLoad], instrD[armIsaPkg::bitImm]})
          2'b10:   ctlWord = 9'b00_01_1_1_1_0_0; // LDR, 12-bit offset
          2'b11:   ctlWord = 9'b00_01_0_1_1_0_0; // LDR, register offset
          2'b00:   ctlWord = 9'b10_01_1_0_0_1_0; // STR, 12-bit offset, Rd read as source
          default: ctlWord = 9'b10_01_0_0_0_1_0; // STR, register offset
        endcase
      end
      armIsaPkg::branch: begin
        if (instrD[armIsaPkg::bitImm]) ctlWord = 9'b01_10_1_0_0_0_1; // B, PC plus imm24
      end
      default: ctlWord = 9'b0;
    endcase
  end

  assign {regSrcD, immSrcD, aluSrcD, memtoRegRaw, regWriteRaw, memWriteRaw, branchD} = ctlWord;

  // Writes die for the instruction behind a flush
  assign memtoRegD = memtoRegRaw & liveD;
  assign regWriteD = regWriteRaw & liveD;
  assign memWriteD = memWriteRaw & liveD;

  // ====================
  // ALU control
  // ====================
  always_comb begin
    if (isLoadStore) begin
      aluControlD = instrD[armIsaPkg::bitUp] ? ctrlPkg::aluAdd : ctrlPkg::aluSub;
      flagWriteD  = 2'b00;
    end else if (isDataProc) begin
      aluControlD = instrD[armIsaPkg::opcodeHi:armIsaPkg::opcodeLo];
      flagWriteD  = {2{instrD[armIsaPkg::bitS]}}; // S sets both pairs
    end else begin
      aluControlD = ctrlPkg::aluAdd; // Branch target add
      flagWriteD  = 2'b00;
    end
  end

  // Anything that will move the PC
  assign pcSrcD = branchD | (regWriteD & (instrD[armIsaPkg::rdHi:armIsaPkg::rdLo] == ctrlPkg::pcReg));
  assign byteD  = isLoadStore & instrD[armIsaPkg::bitByte];

  // Instruction following a flush never reaches the memory bus
  flushKillsStore: assert property (@(posedge clk) disable iff (!arstN)
    flushD |=> !memWriteD);

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  wire logic                clk,
  input  wire logic                arstN,
  input  wire logic                stallE,
  input  wire logic                flushE,
  // Decode controls
  input  wire armIsaPkg::instrT    instrD,
  input  wire logic                aluSrcD,
  input  wire logic                memtoRegD,
  input  wire logic                regWriteD,
  input  wire logic                memWriteD,
  input  wire logic                branchD,
  input  wire logic                pcSrcD,
  input  wire logic                byteD,
  input  wire ctrlPkg::aluCtlT     aluControlD,
  input  wire ctrlPkg::flagWriteT  flagWriteD,
  // Datapath and flag sources
  input  wire logic [31:0]         aluResultE,
  input  wire ctrlPkg::flagsT      aluFlagsE,
  input  wire ctrlPkg::flagsT      flagsM,
  input  wire logic                setNextFlagsM,
  input  wire ctrlPkg::flagsT      flagsW,
  input  wire logic                setNextFlagsW,
  input  wire ctrlPkg::flagsT      archFlags,
  // Execute outputs
  output ctrlPkg::aluCtlT          aluControlE,
  output logic                     aluSrcE,
  output logic                     carryInE,
  output logic                     branchTakenE,
  output logic                     memtoRegE,
  output logic                     pcSrcE,      // Ungated, for hazard logic
  // Toward Memory
  output logic                     regWriteGatedE,
  output logic                     memWriteGatedE,
  output logic                     pcSrcGatedE,
  output logic                     byteE,
  output logic [1:0]               byteOffsetE,
  output ctrlPkg::byteMaskT        byteMaskE,
  output ctrlPkg::flagsT           flagsNextE,
  output logic                     setNextFlagsE
);

  localparam int eRegW = 18;

  logic [eRegW-1:0]    eRegD;
  logic [eRegW-1:0]    eRegQ;
  armIsaPkg::condT     condE;
  ctrlPkg::flagWriteT  flagWriteE;
  ctrlPkg::flagsT      flagsE;
  logic                carryInD;
  logic                memtoRegRawE;
  logic                regWriteE;
  logic                memWriteE;
  logic                branchE;
  logic                condExE;

  // Subtract-type ops run as A + ~B + 1
  assign carryInD = (aluControlD == ctrlPkg::aluSub) | (aluControlD == ctrlPkg::aluRsb)
                  | (aluControlD == ctrlPkg::aluCmp);

  // ====================
  // E register
  // ====================
  assign eRegD = {instrD[armIsaPkg::condHi:armIsaPkg::condLo], aluControlD, flagWriteD,
                  carryInD, aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, pcSrcD, byteD};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      eRegQ <= '0;
    end else if (flushE) begin
      eRegQ <= '0;    // Bubble
    end else if (!stallE) begin
      eRegQ <= eRegD;
    end
  end

  assign condE = armIsaPkg::condT'(eRegQ[17:14]);
  assign {aluControlE, flagWriteE, carryInE, aluSrcE, memtoRegRawE, regWriteE, memWriteE,
          branchE, pcSrcE, byteE} = eRegQ[13:0];

  // Youngest flag producer wins
  assign flagsE = setNextFlagsM ? flagsM : (setNextFlagsW ? flagsW : archFlags);

  condCheck condCheck0 (
    .condE         (condE),
    .flagsE        (flagsE),
    .aluFlagsE     (aluFlagsE),
    .flagWriteE    (flagWriteE),
    .condExE       (condExE),
    .flagsNextE    (flagsNextE),
    .setNextFlagsE (setNextFlagsE)
  );

  // ====================
  // Condition gating
  // ====================
  assign branchTakenE   = branchE & condExE;
  assign regWriteGatedE = regWriteE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign memtoRegE      = memtoRegRawE & condExE; // No read for a skipped load
  assign pcSrcGatedE    = pcSrcE & condExE;

  // Store lanes
  assign byteOffsetE = aluResultE[1:0];
  assign byteMaskE   = byteE ? ctrlPkg::byteMaskT'(4'b0001 << aluResultE[1:0])
                             : ctrlPkg::laneAll;

  // A taken branch was decoded as one, unless the register was holding
  takenNeedsBranch: assert property (@(posedge clk) disable iff (!arstN)
    branchTakenE && !$past(stallE) |-> $past(branchD));

endmodule

`default_nettype wire

// File: memWbPipe.sv
`timescale 1ns/1ps
`default_nettype none

module memWbPipe (
  input  wire logic              clk,
  input  wire logic              arstN,
  input  wire logic              stallM,
  input  wire logic              flushM,
  input  wire logic              stallW,
  input  wire logic              flushW,
  // Gated Execute signals
  input  wire logic              regWriteGatedE,
  input  wire logic              memWriteGatedE,
  input  wire logic              pcSrcGatedE,
  input  wire logic              memtoRegE,
  input  wire logic              byteE,
  input  wire logic [1:0]        byteOffsetE,
  input  wire ctrlPkg::byteMaskT byteMaskE,
  input  wire ctrlPkg::flagsT    flagsNextE,
  input  wire logic              setNextFlagsE,
  // Memory stage
  output logic                   memWriteM,
  output logic                   regWriteM,
  output ctrlPkg::byteMaskT      byteMaskM,
  output logic                   pcSrcM,
  output ctrlPkg::flagsT         flagsM,
  output logic                   setNextFlagsM,
  // Writeback stage
  output logic                   regWriteW,
  output logic                   memtoRegW,
  output logic                   pcSrcW,
  output logic                   loadByteW,
  output logic [1:0]             byteOffsetW,
  output ctrlPkg::flagsT         flagsW,
  output logic                   setNextFlagsW,
  output ctrlPkg::flagsT         archFlags
);

  logic [15:0] mRegD;
  logic [15:0] mRegQ;
  logic [10:0] wRegD;
  logic [10:0] wRegQ;
  logic        memtoRegM;
  logic        byteM;
  logic [1:0]  byteOffsetM;

  // ====================
  // M register
  // ====================
  assign mRegD = {memWriteGatedE, regWriteGatedE, memtoRegE, pcSrcGatedE, byteMaskE,
                  byteE, byteOffsetE, flagsNextE, setNextFlagsE};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mRegQ <= '0;
    end else if (flushM) begin
      mRegQ <= '0;
    end else if (!stallM) begin
      mRegQ <= mRegD;
    end
  end

  assign {memWriteM, regWriteM, memtoRegM, pcSrcM, byteMaskM, byteM, byteOffsetM,
          flagsM, setNextFlagsM} = mRegQ;

  // ====================
  // W register
  // ====================
  assign wRegD = {regWriteM, memtoRegM, pcSrcM, byteM, byteOffsetM, flagsM, setNextFlagsM};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wRegQ <= '0;
    end else if (flushW) begin
      wRegQ <= '0;
    end else if (!stallW) begin
      wRegQ <= wRegD;
    end
  end

  // Byte flag and offset pick and extend the loaded lane
  assign {regWriteW, memtoRegW, pcSrcW, loadByteW, byteOffsetW, flagsW, setNextFlagsW} = wRegQ;

  // Architectural NZCV, committed as the instruction leaves W
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      archFlags <= '0;
    end else if (setNextFlagsW && !stallW) begin
      archFlags <= flagsW;
    end
  end

  // Only a committing flag setter may touch NZCV
  flagsOnlyOnCommit: assert property (@(posedge clk) disable iff (!arstN)
    !setNextFlagsW |=> $stable(archFlags));

endmodule

`default_nettype wire

// File: armController.sv
`timescale 1ns/1ps
`default_nettype none

module armController (
  input  wire logic              clk,
  input  wire logic              arstN,
  input  wire armIsaPkg::instrT  instrD,
  input  wire logic [31:0]       aluResultE,
  input  wire ctrlPkg::flagsT    aluFlagsE,
  // Hazard unit
  input  wire logic              stallD,
  input  wire logic              flushD,
  input  wire logic              stallE,
  input  wire logic              flushE,
  input  wire logic              stallM,
  input  wire logic              flushM,
  input  wire logic              stallW,
  input  wire logic              flushW,
  // Decode
  output ctrlPkg::srcSelT        regSrcD,
  output ctrlPkg::srcSelT        immSrcD,
  output logic                   aluSrcD,
  output logic                   memtoRegD,
  output logic                   regWriteD,
  output logic                   memWriteD,
  output logic                   branchD,
  output logic                   pcSrcD,
  output logic                   byteD,
  output ctrlPkg::aluCtlT        aluControlD,
  output ctrlPkg::flagWriteT     flagWriteD,
  // Execute
  output ctrlPkg::aluCtlT        aluControlE,
  output logic                   aluSrcE,
  output logic                   carryInE,
  output logic                   branchTakenE,
  output logic                   memtoRegE,
  output logic                   pcSrcE,
  // Memory
  output logic                   memWriteM,
  output ctrlPkg::byteMaskT      byteMaskM,
  output logic                   regWriteM,
  // Writeback
  output logic                   regWriteW,
  output logic                   memtoRegW,
  output logic                   pcSrcW,
  output logic                   loadByteW,
  output logic [1:0]             byteOffsetW,
  output ctrlPkg::flagsT         archFlags,
  output logic                   pcWrPendingF
);

  // Between Execute and Memory
  logic              regWriteGatedE;
  logic              memWriteGatedE;
  logic              pcSrcGatedE;
  logic              byteE;
  logic [1:0]        byteOffsetE;
  ctrlPkg::byteMaskT byteMaskE;
  ctrlPkg::flagsT    flagsNextE;
  logic              setNextFlagsE;
  // Flag forwarding back into Execute
  ctrlPkg::flagsT    flagsM;
  logic              setNextFlagsM;
  ctrlPkg::flagsT    flagsW;
  logic              setNextFlagsW;
  logic              pcSrcM;

  // Port names match the stage nets one to one
  mainDecoder  mainDecoder0  (.*);
  executeStage executeStage0 (.*);
  memWbPipe    memWbPipe0    (.*);

  // PC write still in flight, fetch must wait
  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;

endmodule

`default_nettype wire

// File: tbArmController.sv
`timescale 1ns/1ps
`default_nettype none

module tbArmController;

  localparam logic [31:0] idleInstr = 32'hEC00_0000; // AL in coprocessor space, no controls

  // Expected controls of one instruction as it moves down the pipe
  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic [3:0] aluCtl;
    logic       aluSrc;
    logic       carryIn;
    logic       regWrite;
    logic       memtoReg;
    logic       memWrite;
    logic       branch;   // Taken once past E
    logic       pcSrc;    // Gated once past E
    logic       pcSrcU;   // Ungated copy for hazard logic
    logic       byteAcc;
    logic       sBit;
    logic       setFlags;
    logic [3:0] cond;
    logic [3:0] aluFlg;
    logic [3:0] mask;
    logic [1:0] offset;
  } ctlRec;

  logic clk;
  logic arstN;
  armIsaPkg::instrT   instrD;
  logic [31:0]        aluResultE;
  ctrlPkg::flagsT     aluFlagsE;
  logic stallD;
  logic flushD;
  logic stallE;
  logic flushE;
  logic stallM;
  logic flushM;
  logic stallW;
  logic flushW;
  ctrlPkg::srcSelT    regSrcD;
  ctrlPkg::srcSelT    immSrcD;
  logic aluSrcD;
  logic memtoRegD;
  logic regWriteD;
  logic memWriteD;
  logic branchD;
  logic pcSrcD;
  logic byteD;
  ctrlPkg::aluCtlT    aluControlD;
  ctrlPkg::flagWriteT flagWriteD;
  ctrlPkg::aluCtlT    aluControlE;
  logic aluSrcE;
  logic carryInE;
  logic branchTakenE;
  logic memtoRegE;
  logic pcSrcE;
  logic memWriteM;
  ctrlPkg::byteMaskT  byteMaskM;
  logic regWriteM;
  logic regWriteW;
  logic memtoRegW;
  logic pcSrcW;
  logic loadByteW;
  logic [1:0]         byteOffsetW;
  ctrlPkg::flagsT     archFlags;
  logic pcWrPendingF;

  ctlRec          expD;
  ctlRec          expE;
  ctlRec          expM;
  ctlRec          expW;
  ctrlPkg::flagsT expArch;
  ctrlPkg::flagsT modelFlags; // NZCV in program order
  logic [31:0]    pendRes;    // Datapath values for the instruction now in D
  logic [3:0]     pendFlg;
  integer seed;
  int     errors;
  int     errAtStart;
  int     testsRun;
  int     timedOut;
  string  testName;

  armController dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================
  // Reference rules
  // ====================
  function automatic ctlRec decode(input logic [31:0] ins, input logic [3:0] flg);
    ctlRec r;
    r        = '0;
    r.cond   = ins[armIsaPkg::condHi:armIsaPkg::condLo];
    r.aluFlg = flg;
    r.aluCtl = ctrlPkg::aluAdd;
    case (ins[armIsaPkg::classHi:armIsaPkg::classLo])
      2'b00: begin // Data processing, both operand forms
        r.aluSrc   = ins[armIsaPkg::bitImm];
        r.regWrite = 1'b1;
        r.aluCtl   = ins[armIsaPkg::opcodeHi:armIsaPkg::opcodeLo];
        r.sBit     = ins[armIsaPkg::bitS];
      end
      2'b01: begin
        r.aluSrc   = !ins[armIsaPkg::bitImm]; // I set means register offset
        r.regWrite = ins[armIsaPkg::bitLoad];
        r.memtoReg = ins[armIsaPkg::bitLoad];
        r.memWrite = !ins[armIsaPkg::bitLoad];
        r.byteAcc  = ins[armIsaPkg::bitByte];
        r.aluCtl   = ins[armIsaPkg::bitUp] ? ctrlPkg::aluAdd : ctrlPkg::aluSub;
        r.regSrc   = {!ins[armIsaPkg::bitLoad], 1'b0}; // STR reads Rd as store data
        r.immSrc   = 2'b01;                            // 12-bit offset
      end
      2'b10: begin
        r.aluSrc = ins[armIsaPkg::bitImm]; // B only, LDM stays empty
        r.branch = ins[armIsaPkg::bitImm];
        if (r.branch) begin
          r.regSrc = 2'b01; // PC as base
          r.immSrc = 2'b10; // imm24
        end
      end
      default: ;
    endcase
    case (r.aluCtl)
      4'b0010, 4'b0011, 4'b1010: r.carryIn = 1'b1; // SUB, RSB, CMP
      default:                   r.carryIn = 1'b0;
    endcase
    r.pcSrc  = r.branch | (r.regWrite & (ins[armIsaPkg::rdHi:armIsaPkg::rdLo] == ctrlPkg::pcReg));
    r.pcSrcU = r.pcSrc;
    return r;
  endfunction

  // Conditions come in pairs, bit 0 inverts
  function automatic logic condHolds(input logic [3:0] c, input logic [3:0] f);
    logic base;
    case (c[3:1])
      3'd0: base = f[ctrlPkg::flagZ];
      3'd1: base = f[ctrlPkg::flagC];
      3'd2: base = f[ctrlPkg::flagN];
      3'd3: base = f[ctrlPkg::flagV];
      3'd4: base = f[ctrlPkg::flagC] && !f[ctrlPkg::flagZ];      // HI/LS
      3'd5: base = f[ctrlPkg::flagN] == f[ctrlPkg::flagV];       // GE/LT
      3'd6: base = !f[ctrlPkg::flagZ] && (f[ctrlPkg::flagN] == f[ctrlPkg::flagV]);
      default: base = 1'b1;
    endcase
    return (c == armIsaPkg::condNV) ? 1'b0 : base ^ c[0];
  endfunction

  // Byte lanes, little endian
  function automatic logic [3:0] laneMask(input logic byteAcc, input logic [1:0] addr);
    if (!byteAcc) return 4'b1111;
    case (addr)
      2'd0:    return 4'b0001;
      2'd1:    return 4'b0010;
      2'd2:    return 4'b0100;
      default: return 4'b1000;
    endcase
  endfunction

  // Shadow pipe, same stall and flush rules as the hazard ports
  always @(posedge clk or negedge arstN) begin
    ctlRec e;
    ctlRec m;
    logic  taken;
    if (!arstN) begin
      expE       <= '0;
      expM       <= '0;
      expW       <= '0;
      expArch    <= '0;
      modelFlags = '0;
    end else begin
      e = expD;
      m = expE;
      if (!flushE && !stallE) begin
        taken      = condHolds(e.cond, modelFlags);
        e.branch   = e.branch & taken;
        e.regWrite = e.regWrite & taken;
        e.memWrite = e.memWrite & taken;
        e.memtoReg = e.memtoReg & taken;
        e.pcSrc    = e.pcSrc & taken;
        e.setFlags = e.sBit & taken;
        if (e.setFlags) modelFlags = e.aluFlg; // S writes both pairs
      end
      m.mask   = laneMask(m.byteAcc, aluResultE[1:0]); // Lane from the address
      m.offset = aluResultE[1:0];
      if (flushE) expE <= '0;
      else if (!stallE) expE <= e;
      if (flushM) expM <= '0;
      else if (!stallM) expM <= m;
      if (flushW) expW <= '0;
      else if (!stallW) expW <= expM;
      if (expW.setFlags && !stallW) expArch <= expW.aluFlg;
    end
  end

  task automatic reportMismatch(input string what, input logic [31:0] expV,
                                input logic [31:0] actV);
    errors++;
    $display("Mismatch in %s: %s expected %h actual %h", testName, what, expV, actV);
  endtask

  // ====================
  // Checks
  // ====================
  resetState: assert property (@(posedge clk) $rose(arstN) |->
      {regWriteW, memtoRegW, pcSrcW, memWriteM, regWriteM, byteMaskM, branchTakenE,
       aluControlE, pcWrPendingF, archFlags} == '0)
    else reportMismatch("controls after reset", 0, $sampled({regWriteW, memtoRegW, pcSrcW,
      memWriteM, regWriteM, byteMaskM, branchTakenE, aluControlE, pcWrPendingF, archFlags}));

  dStage: assert property (@(posedge clk) disable iff (!arstN)
      {regSrcD, immSrcD, aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, pcSrcD, byteD,
       aluControlD, flagWriteD}
        == {expD.regSrc, expD.immSrc, expD.aluSrc, expD.memtoReg, expD.regWrite,
            expD.memWrite, expD.branch, expD.pcSrc, expD.byteAcc, expD.aluCtl,
            {2{expD.sBit}}})
    else reportMismatch("Decode controls",
      $sampled({expD.regSrc, expD.immSrc, expD.aluSrc, expD.memtoReg, expD.regWrite,
                expD.memWrite, expD.branch, expD.pcSrc, expD.byteAcc, expD.aluCtl,
                {2{expD.sBit}}}),
      $sampled({regSrcD, immSrcD, aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, pcSrcD,
                byteD, aluControlD, flagWriteD}));

  eStage: assert property (@(posedge clk) disable iff (!arstN)
      {aluControlE, aluSrcE, carryInE, branchTakenE, memtoRegE, pcSrcE}
        == {expE.aluCtl, expE.aluSrc, expE.carryIn, expE.branch, expE.memtoReg, expE.pcSrcU})
    else reportMismatch("aluControlE aluSrcE carryInE branchTakenE memtoRegE pcSrcE",
      $sampled({expE.aluCtl, expE.aluSrc, expE.carryIn, expE.branch, expE.memtoReg,
                expE.pcSrcU}),
      $sampled({aluControlE, aluSrcE, carryInE, branchTakenE, memtoRegE, pcSrcE}));

  mStage: assert property (@(posedge clk) disable iff (!arstN)
      {memWriteM, regWriteM, byteMaskM} == {expM.memWrite, expM.regWrite, expM.mask})
    else reportMismatch("memWriteM regWriteM byteMaskM",
      $sampled({expM.memWrite, expM.regWrite, expM.mask}),
      $sampled({memWriteM, regWriteM, byteMaskM}));

  wStage: assert property (@(posedge clk) disable iff (!arstN)
      {regWriteW, memtoRegW, pcSrcW, loadByteW, byteOffsetW}
        == {expW.regWrite, expW.memtoReg, expW.pcSrc, expW.byteAcc, expW.offset})
    else reportMismatch("regWriteW memtoRegW pcSrcW loadByteW byteOffsetW",
      $sampled({expW.regWrite, expW.memtoReg, expW.pcSrc, expW.byteAcc, expW.offset}),
      $sampled({regWriteW, memtoRegW, pcSrcW, loadByteW, byteOffsetW}));

  archState: assert property (@(posedge clk) disable iff (!arstN) archFlags == expArch)
    else reportMismatch("archFlags", $sampled(expArch), $sampled(archFlags));

  pcPending: assert property (@(posedge clk) disable iff (!arstN)
      pcWrPendingF == (expD.pcSrc | expE.pcSrcU | expM.pcSrc))
    else reportMismatch("pcWrPendingF", $sampled(expD.pcSrc | expE.pcSrcU | expM.pcSrc),
      $sampled(pcWrPendingF));

  // ====================
  // Stimulus
  // ====================
  task automatic makeInstr(input logic [1:0] cls, input logic [3:0] cond,
                           output logic [31:0] ins);
    ins = $random(seed);
    ins[armIsaPkg::condHi:armIsaPkg::condLo]   = cond;
    ins[armIsaPkg::classHi:armIsaPkg::classLo] = cls;
    if (cls == armIsaPkg::branch) ins[armIsaPkg::bitImm] = 1'b1; // B, not LDM
  endtask

  // New instruction into D, datapath values for the one entering E
  task automatic issue(input logic [31:0] ins);
    logic [31:0] res;
    logic [31:0] flg;
    res = $random(seed);
    flg = $random(seed);
    @(posedge clk);
    instrD     <= ins;
    expD       <= decode(ins, flg[3:0]);
    aluResultE <= pendRes;
    aluFlagsE  <= pendFlg;
    stallD     <= 1'b0;
    stallE     <= 1'b0;
    flushE     <= 1'b0;
    flushM     <= 1'b0;
    pendRes    = res;
    pendFlg    = flg[3:0];
  endtask

  task automatic stallFor(input int k);
    issue(idleInstr);
    stallD <= 1'b1;
    stallE <= 1'b1;
    flushM <= 1'b1;   // Bubble behind the held E stage
    repeat (k) @(posedge clk);
    stallD <= 1'b0;
    stallE <= 1'b0;
    flushM <= 1'b0;
  endtask

  task automatic waitForWb(input int limit, output int edges);
    edges = 0;
    do begin
      issue(idleInstr);
      edges++;
      @(negedge clk);
    end while (!regWriteW && edges < limit);
    if (!regWriteW) begin
      timedOut++;
      $display("Timeout in %s: no register write reached Writeback", testName);
    end
  endtask

  task automatic startTest(input string name);
    testName   = name;
    errAtStart = errors;
  endtask

  task automatic endTest();
    repeat (5) issue(idleInstr); // Drain through archFlags
    testsRun++;
    $display("Test %s done with %0d mismatches", testName, errors - errAtStart);
  endtask

  initial begin
    logic [31:0] ins;
    logic [1:0]  cls;
    int          k;
    int          edges;
    seed       = 32'h9310_a18e;
    errors     = 0;
    testsRun   = 0;
    timedOut   = 0;
    arstN      = 1'b0;
    instrD     = idleInstr;
    aluResultE = '0;
    aluFlagsE  = '0;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    pendRes    = '0;
    pendFlg    = '0;
    expD       = decode(idleInstr, 4'h0);
    repeat (16) @(posedge clk);
    arstN <= 1'b1;

    startTest("reset state");
    endTest();

    startTest("decode timing");
    repeat (40) begin
      cls = $random(seed);
      if (cls == 2'b11) cls = 2'b00;
      makeInstr(cls, armIsaPkg::condAL, ins);
      issue(ins);
    end
    endTest();

    startTest("condition gating");
    makeInstr(armIsaPkg::dataProc, armIsaPkg::condAL, ins);
    ins[armIsaPkg::bitS] = 1'b1; // Known flags first
    issue(ins);
    repeat (40) begin
      cls = ($random(seed) & 1) ? armIsaPkg::branch : armIsaPkg::dataProc;
      makeInstr(cls, 4'($random(seed)), ins);
      issue(ins);
    end
    endTest();

    startTest("flag update");
    repeat (12) begin
      makeInstr(armIsaPkg::dataProc, armIsaPkg::condAL, ins);
      ins[armIsaPkg::bitS] = 1'b1;
      issue(ins);
      repeat (2) begin // Readers of the forwarded flags
        makeInstr(armIsaPkg::dataProc, 4'($random(seed)), ins);
        issue(ins);
      end
    end
    endTest();

    startTest("store byte mask");
    repeat (16) begin
      makeInstr(armIsaPkg::loadStore, armIsaPkg::condAL, ins);
      ins[armIsaPkg::bitLoad] = 1'b0;
      issue(ins);
    end
    endTest();

    startTest("flush execute");
    makeInstr(armIsaPkg::dataProc, armIsaPkg::condAL, ins);
    ins[armIsaPkg::bitS] = 1'b0;
    issue(ins);
    makeInstr(armIsaPkg::dataProc, armIsaPkg::condAL, ins);
    issue(ins);
    flushE <= 1'b1;   // This one never enters E
    endTest();

    startTest("stall execute");
    repeat (3) begin
      k = 1 + ($random(seed) & 3);
      makeInstr(armIsaPkg::dataProc, armIsaPkg::condAL, ins);
      ins[armIsaPkg::bitS] = 1'b0;
      issue(ins);
      stallFor(k);
      waitForWb(12, edges);
      if (regWriteW && edges + k + 1 != k + 3) reportMismatch("edges to W", k + 3, edges + k + 1);
      repeat (2) issue(idleInstr);
    end
    endTest();

    $display("Summary: %0d tests, %0d failed checks, %0d timeouts", testsRun, errors, timedOut);
    if (errors == 0 && timedOut == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
armIsaPkg.sv
ctrlPkg.sv
condCheck.sv
mainDecoder.sv
executeStage.sv
memWbPipe.sv
armController.sv
tbArmController.sv
